// File: common/arb_demo_pkg.sv
// shared constants and types for the arbiter demonstration board
// covers widths, tick scaling, debounce and stretch lengths and the request patterns
package arb_demo_pkg;

	// number of requesters and the width of an encoded grant index
	localparam int WIDTH = 8;
	localparam int SELECT_WIDTH = 3;

	typedef logic [SELECT_WIDTH-1:0] select_t;
	typedef logic [WIDTH-1:0] req_t;

	// tick chain, scaled far below real time so that a simulation stays short
	localparam int CLOCKS_PER_USEC = 4;
	localparam int USEC_PER_MSEC = 5;

	// lengths counted in millisecond ticks
	localparam int DEBOUNCE_MSEC = 3;
	localparam int STRETCH_MSEC = 3;

	// the first tick after a load only lines the counter up with the millisecond grid,
	// so each counter starts one above its nominal length to give whole tick periods
	localparam int DEBOUNCE_LOAD = DEBOUNCE_MSEC + 1;
	localparam int STRETCH_LOAD = STRETCH_MSEC + 1;
	localparam int LOCK_WIDTH = $clog2(DEBOUNCE_LOAD + 1);
	localparam int HOLD_WIDTH = $clog2(STRETCH_LOAD + 1);

	// request patterns stepped through by the next test button
	localparam int NUM_PATTERNS = 4;
	localparam int PATTERN_WIDTH = $clog2(NUM_PATTERNS);

	typedef logic [PATTERN_WIDTH-1:0] pattern_t;

	// all requesters, the even ones, the two ends, and requester 4 alone
	localparam req_t REQ_PATTERNS [NUM_PATTERNS] = '{
		req_t'(8'hff),
		req_t'(8'h55),
		req_t'(8'h81),
		req_t'(8'h10)
	};

endpackage

// File: common/arb_if.sv
// request and grant bundle between the demo sequencer and the arbiter
// master and slave modports
`timescale 1ns/10ps

interface arb_if import arb_demo_pkg::*; ();

	// requests and one-cycle commands from the sequencer
	req_t req;
	logic advance;
	logic clear;

	// registered grant with its encoded index and a valid flag
	req_t grant;
	select_t select;
	logic valid;

	// the sequencer side issues requests and commands
	modport master (
		output req, advance, clear,
		input grant, select, valid
	);

	// the arbiter side answers with the grant
	modport slave (
		input req, advance, clear,
		output grant, select, valid
	);

endinterface

// File: design/pulser.sv
// enabled down-counter that emits a one-cycle pulse every count enables
`timescale 1ns/10ps

module pulser #(
	parameter int count = 4
) (
	input logic clock,
	input logic rst_n,
	input logic enable,
	output logic pulse
);

	// a count of one still needs a counter bit
	localparam int CNT_W = (count > 1) ? $clog2(count) : 1;

	logic [CNT_W-1:0] cnt;

	// the counter holds the number of enables left before the next pulse,
	// and the reload happens on the same enable that fires the pulse,
	// so the period is exactly count enables whether enable is steady or sparse
	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cnt <= CNT_W'(count - 1);
			pulse <= 1'b0;
		end
		else
		begin
			pulse <= 1'b0;
			if (enable)
			begin
				if (cnt == '0)
				begin
					cnt <= CNT_W'(count - 1);
					pulse <= 1'b1;
				end
				else
				begin
					cnt <= cnt - 1'b1;
				end
			end
		end
	end

endmodule

// File: design/debouncer.sv
// button debouncer with a two-flop synchroniser, rising-edge detector
// and a millisecond lockout that accepts one event per lockout period
`timescale 1ns/10ps

module debouncer import arb_demo_pkg::*; (
	input logic clock,
	input logic rst_n,
	input logic msec_tick,
	input logic button,
	output logic rising_pulse
);

	// sync_q[0] is the metastability catcher, sync_q[1] the clean level
	logic [1:0] sync_q;
	// the clean level one clock ago, for edge detection
	logic prev_q;
	// millisecond ticks left before another edge is accepted
	logic [LOCK_WIDTH-1:0] lockout;
	logic edge_seen;

	// buttons are normally low, so a press shows up as a rising edge
	assign edge_seen = sync_q[1] & ~prev_q;

	// an edge seen at clock n reaches sync_q[1] at n+1 and the pulse at n+2
	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sync_q <= '0;
			prev_q <= 1'b0;
			lockout <= '0;
			rising_pulse <= 1'b0;
		end
		else
		begin
			sync_q <= {sync_q[0], button};
			prev_q <= sync_q[1];
			rising_pulse <= 1'b0;
			if (edge_seen && lockout == '0)
			begin
				// accept the press and start the lockout
				rising_pulse <= 1'b1;
				lockout <= LOCK_WIDTH'(DEBOUNCE_LOAD);
			end
			else if (msec_tick && lockout != '0)
			begin
				// contact bounce and quick second presses fall in here and are dropped
				lockout <= lockout - 1'b1;
			end
		end
	end

endmodule

// File: design/stretcher.sv
// display stretcher that holds each newly shown value for a minimum time
// works on any payload type
`timescale 1ns/10ps

module stretcher import arb_demo_pkg::*; #(
	parameter type payload_t = logic
) (
	input logic clock,
	input logic rst_n,
	input logic msec_tick,
	input payload_t in,
	output payload_t out
);

	// millisecond ticks left before the shown value may change again
	logic [HOLD_WIDTH-1:0] hold;

	// a new value is taken only when the previous one has been shown long enough,
	// so a one-cycle blip such as the arbiter wrap still gets its full hold time
	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out <= payload_t'('0);
			hold <= '0;
		end
		else
		begin
			if (hold == '0)
			begin
				if (in != out)
				begin
					out <= in;
					hold <= HOLD_WIDTH'(STRETCH_LOAD);
				end
			end
			else if (msec_tick)
			begin
				hold <= hold - 1'b1;
			end
		end
	end

	// an input that changes and returns during the hold never shows,
	// the output only follows whatever the input is once the hold runs out

endmodule

// File: arbiter/rr_arbiter.sv
// round-robin arbiter with a registered one-hot grant
// inserts a one-cycle no-grant blip whenever the search wraps around
`timescale 1ns/10ps

module rr_arbiter import arb_demo_pkg::*; (
	input logic clock,
	input logic rst_n,
	arb_if.slave arb
);

	// last granted index, the priority pointer
	select_t last;
	// clear until the first grant, so that the search starts at index 0
	logic have_last;
	// a wrap is waiting out its blip cycle
	logic wrap_q;
	select_t target_q;

	req_t above;
	logic found_above;
	logic found_any;
	select_t idx_above;
	select_t idx_any;

	// lowest set bit of a vector, the return value says whether there was one
	function automatic logic find_first(input req_t vec, output select_t idx);
		logic found;
		found = 1'b0;
		idx = '0;
		for (int i = WIDTH - 1; i >= 0; i--)
		begin
			if (vec[i])
			begin
				found = 1'b1;
				idx = select_t'(i);
			end
		end
		return found;
	endfunction

	// requests strictly above the pointer, or all of them before any grant
	always_comb
	begin
		for (int i = 0; i < WIDTH; i++)
			above[i] = arb.req[i] & (!have_last || select_t'(i) > last);
		found_above = find_first(above, idx_above);
		found_any = find_first(arb.req, idx_any);
	end

	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			arb.grant <= '0;
			last <= '0;
			have_last <= 1'b0;
			wrap_q <= 1'b0;
			target_q <= '0;
		end
		else if (arb.clear)
		begin
			// new pattern, start the search from index 0 again
			arb.grant <= '0;
			have_last <= 1'b0;
			wrap_q <= 1'b0;
		end
		else if (wrap_q)
		begin
			// blip is over, an advance landing here is dropped
			arb.grant <= req_t'(1) << target_q;
			last <= target_q;
			have_last <= 1'b1;
			wrap_q <= 1'b0;
		end
		else if (arb.advance)
		begin
			arb.grant <= '0;
			if (found_above)
			begin
				arb.grant <= req_t'(1) << idx_above;
				last <= idx_above;
				have_last <= 1'b1;
			end
			else if (found_any)
			begin
				// at or below the last grant, spend one cycle with nothing granted
				wrap_q <= 1'b1;
				target_q <= idx_any;
			end
		end
	end

	// index and flag follow the registered grant, so both blip with it
	always_comb
	begin
		arb.select = '0;
		for (int i = 0; i < WIDTH; i++)
			if (arb.grant[i])
				arb.select = select_t'(i);
	end

	assign arb.valid = |arb.grant;

endmodule

// File: arbiter/demo_sequencer.sv
// demo sequencer that picks the request pattern and turns the
// debounced button pulses into arbiter advance and clear commands
`timescale 1ns/10ps

module demo_sequencer import arb_demo_pkg::*; (
	input logic clock,
	input logic rst_n,
	input logic next_test,
	input logic next_step,
	arb_if.master arb
);

	// index into the request pattern table
	pattern_t pat_idx;
	pattern_t pat_next;

	// step to the following pattern, back to the first after the last one
	always_comb
	begin
		if (pat_idx == pattern_t'(NUM_PATTERNS - 1))
			pat_next = '0;
		else
			pat_next = pat_idx + 1'b1;
	end

	// the pattern index moves on the same edge that raises clear,
	// so the arbiter sees the new requests in the cycle it is cleared
	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pat_idx <= '0;
		end
		else if (next_test)
		begin
			pat_idx <= pat_next;
		end
	end

	// commands are one cycle behind the button pulses
	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			arb.advance <= 1'b0;
			arb.clear <= 1'b0;
		end
		else
		begin
			arb.advance <= next_step;
			// both may fire together, the arbiter lets clear win
			arb.clear <= next_test;
		end
	end

	// requests come straight from the table, there is nothing to program them
	assign arb.req = REQ_PATTERNS[pat_idx];

	// the grant side of the bundle is left to the arbiter and the display,
	// this block never needs to see it because nothing can push back

endmodule

// File: design/arb_demo_top.sv
// top level of the arbiter demonstration board
// tick chain, button debouncers, sequencer, arbiter and display stretchers
`timescale 1ns/10ps

module arb_demo_top import arb_demo_pkg::*; (
	input logic clock,
	input logic rst_n,
	input logic [1:0] buttons,
	output logic [SELECT_WIDTH:0] indicators
);

	logic usec_tick;
	logic msec_tick;
	logic next_test;
	logic next_step;

	arb_if arb ();

	// microsecond tick, always counting
	pulser #(.count(CLOCKS_PER_USEC)) usec_pulser (
		.clock(clock),
		.rst_n(rst_n),
		.enable(1'b1),
		.pulse(usec_tick)
	);

	// millisecond tick, counting microsecond ticks
	pulser #(.count(USEC_PER_MSEC)) msec_pulser (
		.clock(clock),
		.rst_n(rst_n),
		.enable(usec_tick),
		.pulse(msec_tick)
	);

	// button 1 moves to the next pattern, button 0 steps the arbiter
	debouncer next_test_debouncer (
		.clock(clock),
		.rst_n(rst_n),
		.msec_tick(msec_tick),
		.button(buttons[1]),
		.rising_pulse(next_test)
	);

	debouncer next_step_debouncer (
		.clock(clock),
		.rst_n(rst_n),
		.msec_tick(msec_tick),
		.button(buttons[0]),
		.rising_pulse(next_step)
	);

	demo_sequencer u_sequencer (
		.clock(clock),
		.rst_n(rst_n),
		.next_test(next_test),
		.next_step(next_step),
		.arb(arb.master)
	);

	rr_arbiter u_arbiter (
		.clock(clock),
		.rst_n(rst_n),
		.arb(arb.slave)
	);

	// stretched so that the wrap blip on select and valid stays visible
	stretcher #(.payload_t(select_t)) select_stretcher (
		.clock(clock),
		.rst_n(rst_n),
		.msec_tick(msec_tick),
		.in(arb.select),
		.out(indicators[SELECT_WIDTH:1])
	);

	stretcher #(.payload_t(logic)) valid_stretcher (
		.clock(clock),
		.rst_n(rst_n),
		.msec_tick(msec_tick),
		.in(arb.valid),
		.out(indicators[0])
	);

endmodule

// File: verification/arb_demo_tb.sv
// testbench for the arbiter demonstration board
// button stimulus, a reference model of the sequencer and arbiter, and display checks
`timescale 1ns/10ps

module arb_demo_tb import arb_demo_pkg::*; ();

	// shortest time any displayed value may stay on the indicators
	localparam int MIN_HOLD_CLOCKS = STRETCH_MSEC * USEC_PER_MSEC * CLOCKS_PER_USEC;
	localparam int PRESS_CLOCKS = 6;
	// a repeated press lands well inside the debounce lockout
	localparam int REPRESS_GAP = 14;
	localparam int MIN_GAP = 100;
	localparam int WAIT_LIMIT = 400;

	logic clock;
	logic rst_n;
	logic [1:0] buttons;
	logic [SELECT_WIDTH:0] indicators;

	integer seed;

	// reference model state, moved only by presses that the debouncer accepts
	int model_pattern;
	int model_last;
	bit model_have_last;

	// display monitor state
	select_t shown_select;
	logic shown_valid;
	int select_held;
	int valid_held;

	arb_demo_top u_dut (
		.clock(clock),
		.rst_n(rst_n),
		.buttons(buttons),
		.indicators(indicators)
	);

	always #10 clock = ~clock;

	task automatic report_error(input string msg);
		$display("error at %0t ns: %s", $time, msg);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic report_timeout(input string what);
		$display("timed out at %0t ns while waiting for the %s on the indicators", $time, what);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	// request vectors as the board describes them
	function automatic req_t pattern_requests(input int pattern);
		case (pattern)
			0: return 8'b1111_1111;
			1: return 8'b0101_0101;
			2: return 8'b1000_0001;
			default: return 8'b0001_0000;
		endcase
	endfunction

	// next requester above the last grant, going round if nothing is above it
	task automatic model_step(output int sel, output bit wrapped);
		req_t req;
		int idx;
		req = pattern_requests(model_pattern);
		sel = -1;
		wrapped = 1'b0;
		for (int k = 0; k < WIDTH; k++)
		begin
			idx = model_have_last ? (model_last + 1 + k) % WIDTH : k;
			if (sel < 0 && req[idx])
				sel = idx;
		end
		if (model_have_last && sel <= model_last)
			wrapped = 1'b1;
		model_last = sel;
		model_have_last = 1'b1;
	endtask

	// a press, or a press and a quick second press that must be ignored
	task automatic press_button(input int index, input bit twice);
		@(posedge clock);
		buttons[index] <= 1'b1;
		repeat (PRESS_CLOCKS) @(posedge clock);
		buttons[index] <= 1'b0;
		if (twice)
		begin
			repeat (REPRESS_GAP) @(posedge clock);
			buttons[index] <= 1'b1;
			repeat (PRESS_CLOCKS) @(posedge clock);
			buttons[index] <= 1'b0;
		end
	endtask

	task automatic wait_for_indicators(input logic [SELECT_WIDTH:0] expected, input string what);
		int cycles;
		cycles = 0;
		while (indicators !== expected)
		begin
			@(posedge clock);
			cycles++;
			if (cycles > WAIT_LIMIT)
				report_timeout(what);
		end
	endtask

	// idle past the lockout and the hold, the shown value must not move meanwhile
	task automatic hold_and_check(input logic [SELECT_WIDTH:0] expected);
		int gap;
		gap = MIN_GAP + ($unsigned($random(seed)) % 40);
		repeat (gap)
		begin
			@(posedge clock);
			assert (indicators === expected)
			else
				report_error($sformatf("indicators %b, expected %b", indicators, expected));
		end
	endtask

	task automatic step_arbiter(input bit twice);
		int sel;
		bit wrapped;
		logic [SELECT_WIDTH:0] expected;
		model_step(sel, wrapped);
		expected = {select_t'(sel), 1'b1};
		press_button(0, twice);
		// a wrap first shows the no-grant blip, select and valid both low
		if (wrapped)
			wait_for_indicators('0, "wrap blip");
		wait_for_indicators(expected, $sformatf("grant of index %0d", sel));
		hold_and_check(expected);
	endtask

	task automatic next_pattern(input bit twice);
		model_pattern = (model_pattern + 1) % NUM_PATTERNS;
		model_have_last = 1'b0;
		press_button(1, twice);
		wait_for_indicators('0, "cleared grant");
		hold_and_check('0);
	endtask

	// every change of either field must come after the previous value was held long enough
	always @(posedge clock)
	begin
		if (!rst_n)
		begin
			shown_select <= '0;
			shown_valid <= 1'b0;
			select_held <= 0;
			valid_held <= 0;
		end
		else
		begin
			if (indicators[SELECT_WIDTH:1] !== shown_select)
			begin
				assert (select_held >= MIN_HOLD_CLOCKS)
				else
					report_error($sformatf("select held only %0d clocks", select_held));
				shown_select <= indicators[SELECT_WIDTH:1];
				select_held <= 1;
			end
			else
				select_held <= select_held + 1;
			if (indicators[0] !== shown_valid)
			begin
				assert (valid_held >= MIN_HOLD_CLOCKS)
				else
					report_error($sformatf("valid held only %0d clocks", valid_held));
				shown_valid <= indicators[0];
				valid_held <= 1;
			end
			else
				valid_held <= valid_held + 1;
		end
	end

	initial
	begin
		clock = 1'b0;
		rst_n = 1'b0;
		buttons = '0;
		seed = 32'hd2ffd51d;
		model_pattern = 0;
		model_last = 0;
		model_have_last = 1'b0;
		repeat (8) @(posedge clock);
		rst_n <= 1'b1;

		// nothing may show before the first press
		repeat (200)
		begin
			@(posedge clock);
			assert (indicators === '0)
			else
				report_error($sformatf("indicators %b before any press", indicators));
		end

		// all requesters, one full lap and past the wrap
		repeat (10) step_arbiter(1'b0);
		// even requesters, then the two ends, then requester 4 alone
		next_pattern(1'b0);
		repeat (6) step_arbiter(1'b0);
		next_pattern(1'b0);
		repeat (4) step_arbiter(1'b0);
		next_pattern(1'b0);
		repeat (3) step_arbiter(1'b0);

		// quick second presses of each button must leave the model in step
		next_pattern(1'b1);
		step_arbiter(1'b1);
		step_arbiter(1'b1);
		step_arbiter(1'b1);
		step_arbiter(1'b0);

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// File: arb_demo.f
common/arb_demo_pkg.sv
common/arb_if.sv
design/pulser.sv
design/debouncer.sv
design/stretcher.sv
arbiter/rr_arbiter.sv
arbiter/demo_sequencer.sv
design/arb_demo_top.sv
verification/arb_demo_tb.sv
